/* sdram_sched.f */
logic/sdram_sched_pkg.sv
logic/sdram_port_arbiter.sv
logic/sdram_bank_timer.sv
logic/sdram_refresh_timer.sv
logic/sdram_cmd_fsm.sv
logic/sdram_read_return.sv
logic/sdram_sched_top.sv
verif/tb_sdram_sched.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the SDRAM scheduler testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing --timescale 1ns/1ns \
  --top-module tb_sdram_sched -Mdir obj_dir -f sdram_sched.f
build_status=$?
if [ "$build_status" -ne 0 ]; then
  echo "Verilator build failed"
  exit "$build_status"
fi

./obj_dir/Vtb_sdram_sched
sim_status=$?
if [ "$sim_status" -ne 0 ]; then
  echo "Simulation ended with status $sim_status"
  exit "$sim_status"
fi

exit 0

/* verif/tb_sdram_sched.sv */
// Built for PORTS 3, CAS latency 2 and short timings; stops at the first error or timeout
`timescale 1ns/1ns

module tb_sdram_sched;
  import sdram_sched_pkg::*;

  localparam int PORTS            = 3;
  localparam int T_RCD            = 2;
  localparam int T_RP             = 2;
  localparam int T_RAS            = 4;
  localparam int T_RC             = 6;
  localparam int CAS_LATENCY      = 2;
  localparam int REFRESH_INTERVAL = 64;
  localparam int REF_MARGIN       = 40;
  localparam int ACK_TARGET       = 300;
  localparam int RUN_LIMIT        = 50000;
  localparam int DRAIN_LIMIT      = 2000;

  typedef struct packed {
    logic [31:0]          due;
    logic [PORT_BITS-1:0] port;
    logic [DQ_BITS-1:0]   data;
  } rd_exp_t;

  logic                clk;
  logic                rst_n;
  logic [PORTS-1:0]    req_valid;
  sdram_req_t          req [PORTS];
  logic [PORTS-1:0]    ack;
  sdram_bus_t          sdram;
  logic [DQ_BITS-1:0]  sdram_dq;
  logic [DQ_BITS-1:0]  rdq;
  logic [PORTS-1:0]    rdq_valid;

  // Reference memory follows the acks, the SDRAM model follows the bus
  logic [DQ_BITS-1:0]  ref_mem [int];
  logic [DQ_BITS-1:0]  model_mem [int];
  logic [DQ_BITS-1:0]  dq_pipe [CAS_LATENCY+1];
  rd_exp_t             rd_q [$];

  logic                bank_open [BANKS];
  logic [ROW_BITS-1:0] bank_row [BANKS];
  int                  last_act [BANKS];
  int                  last_pre [BANKS];
  int                  last_ref;
  int                  cyc;
  int                  n_acks;
  logic                gnt_expected;
  int                  exp_port;

  sdram_sched_top #(
    .PORTS            (PORTS),
    .T_RCD            (T_RCD),
    .T_RP             (T_RP),
    .T_RAS            (T_RAS),
    .T_RC             (T_RC),
    .CAS_LATENCY      (CAS_LATENCY),
    .REFRESH_INTERVAL (REFRESH_INTERVAL)
  ) u_sdram_sched_top (
    .clk_i       (clk),
    .rst_ni      (rst_n),
    .req_valid_i (req_valid),
    .req_i       (req),
    .ack_o       (ack),
    .sdram_o     (sdram),
    .sdram_dq_i  (sdram_dq),
    .rdq_o       (rdq),
    .rdq_valid_o (rdq_valid)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
      fail_run($sformatf("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp));
  endtask

  // Unwritten words read back a pattern built from every address bit
  function automatic logic [DQ_BITS-1:0] fill_word(input int a);
    return DQ_BITS'(a) ^ DQ_BITS'(a >> 8) ^ 16'h3c5a;
  endfunction

  function automatic logic [DQ_BITS-1:0] merge_bytes(input logic [DQ_BITS-1:0] old_w,
                                                     input logic [DQ_BITS-1:0] new_w,
                                                     input logic [DM_BITS-1:0] en);
    logic [DQ_BITS-1:0] w;
    w = old_w;
    for (int i = 0; i < DM_BITS; i++)
    begin
      if (en[i])
        w[i*8 +: 8] = new_w[i*8 +: 8];
    end
    return w;
  endfunction

  function automatic logic [DQ_BITS-1:0] ref_word(input int a);
    return ref_mem.exists(a) ? ref_mem[a] : fill_word(a);
  endfunction

  function automatic logic [DQ_BITS-1:0] model_word(input int a);
    return model_mem.exists(a) ? model_mem[a] : fill_word(a);
  endfunction

  task automatic check_idle_outputs();
    check_val("sdram_o.cmd", 32'(sdram.cmd), 32'(CMD_NOP));
    check_val("sdram_o.dq_oe", 32'(sdram.dq_oe), 32'd0);
    check_val("ack_o", 32'(ack), 32'd0);
    check_val("rdq_valid_o", 32'(rdq_valid), 32'd0);
  endtask

  //////////////////////////////
  // Bus decode and checks
  //////////////////////////////
  task automatic transfer(input int b);
    sdram_req_t         r;
    logic [DM_BITS-1:0] mask;
    int                 a_ref;
    int                 a_bus;
    if (!gnt_expected)
      fail_run("RD or WR on the bus with no request pending");
    check_val("ack_o", 32'(ack), 32'(1) << exp_port);
    r    = req[exp_port];
    mask = ~r.be;
    check_val("sdram_o.cmd", 32'(sdram.cmd), 32'(r.we ? CMD_WR : CMD_RD));
    check_val("sdram_o.ba", 32'(sdram.ba), 32'(r.ba));
    check_val("sdram_o.addr", 32'(sdram.addr), 32'(r.col));
    if (!bank_open[b])
      fail_run($sformatf("RD or WR to bank %0d while it is closed", b));
    check_val("open row", 32'(bank_row[b]), 32'(r.row));
    if (cyc - last_act[b] < T_RCD)
      fail_run($sformatf("RD or WR to bank %0d too soon after ACT", b));
    a_ref = int'({r.ba, r.row, r.col});
    a_bus = int'({sdram.ba, bank_row[b], sdram.addr[COL_BITS-1:0]});
    if (r.we)
    begin
      check_val("sdram_o.dq", 32'(sdram.dq), 32'(r.wdata));
      check_val("sdram_o.dm", 32'(sdram.dm), 32'(mask));
      model_mem[a_bus] = merge_bytes(model_word(a_bus), sdram.dq, ~sdram.dm);
      ref_mem[a_ref]   = merge_bytes(ref_word(a_ref), r.wdata, r.be);
    end
    else
    begin
      dq_pipe[0] = model_word(a_bus);
      rd_q.push_back('{due: 32'(cyc + CAS_LATENCY + 1), port: PORT_BITS'(exp_port),
                       data: ref_word(a_ref)});
    end
    req_valid[exp_port] = 1'b0;
    gnt_expected        = 1'b0;
    n_acks++;
  endtask

  task automatic track_bus();
    int   b;
    logic xfer;
    b    = int'(sdram.ba);
    xfer = (sdram.cmd == CMD_RD) || (sdram.cmd == CMD_WR);
    check_val("sdram_o.dq_oe", 32'(sdram.dq_oe), 32'(sdram.cmd == CMD_WR));
    if (ack != '0 && !xfer)
      fail_run("acknowledge without a RD or WR on the bus");
    case (sdram.cmd)
      CMD_NOP: ;
      CMD_ACT:
      begin
        if (bank_open[b])
          fail_run($sformatf("ACT to bank %0d while it is open", b));
        if (cyc - last_pre[b] < T_RP)
          fail_run($sformatf("ACT to bank %0d too soon after PRE", b));
        if (cyc - last_ref < T_RC)
          fail_run($sformatf("ACT to bank %0d too soon after REF", b));
        bank_open[b] = 1'b1;
        bank_row[b]  = sdram.addr;
        last_act[b]  = cyc;
      end
      CMD_PRE:
      begin
        if (!bank_open[b])
          fail_run($sformatf("PRE to bank %0d while it is closed", b));
        if (cyc - last_act[b] < T_RAS)
          fail_run($sformatf("PRE to bank %0d too soon after ACT", b));
        bank_open[b] = 1'b0;
        last_pre[b]  = cyc;
      end
      CMD_REF:
      begin
        for (int i = 0; i < BANKS; i++)
        begin
          if (bank_open[i] || cyc - last_pre[i] < T_RP)
            fail_run($sformatf("REF while bank %0d is not idle", i));
        end
        if (cyc - last_ref < T_RC)
          fail_run("REF too soon after the previous REF");
        last_ref = cyc;
      end
      CMD_RD, CMD_WR: transfer(b);
      default: fail_run("unknown command code on the bus");
    endcase
  endtask

  task automatic check_read_return();
    logic [PORTS-1:0] exp_valid;
    exp_valid = '0;
    if (rd_q.size() != 0 && int'(rd_q[0].due) == cyc)
    begin
      exp_valid = PORTS'(1) << rd_q[0].port;
      check_val("rdq_o", 32'(rdq), 32'(rd_q[0].data));
      void'(rd_q.pop_front());
    end
    check_val("rdq_valid_o", 32'(rdq_valid), 32'(exp_valid));
  endtask

  task automatic run_cycle();
    cyc++;
    for (int i = CAS_LATENCY; i > 0; i--)
      dq_pipe[i] = dq_pipe[i-1];
    dq_pipe[0] = '0;
    track_bus();
    check_read_return();
    if (cyc - last_ref > REFRESH_INTERVAL + REF_MARGIN)
      fail_run("no REF within the refresh interval");
    // Model output lines up with the capture edge of the read return
    sdram_dq = dq_pipe[CAS_LATENCY];
  endtask

  //////////////////////////////
  // Stimulus
  //////////////////////////////
  task automatic drive_ports();
    for (int p = 0; p < PORTS; p++)
    begin
      if (!req_valid[p] && $urandom_range(0, 7) == 0)
      begin
        req[p].we    = 1'($urandom_range(0, 1));
        req[p].ba    = BA_BITS'($urandom_range(0, BANKS - 1));
        req[p].row   = ROW_BITS'($urandom_range(0, 1));
        req[p].col   = COL_BITS'($urandom_range(0, 3));
        req[p].wdata = DQ_BITS'($urandom());
        req[p].be    = DM_BITS'($urandom_range(1, 3));
        req_valid[p] = 1'b1;
      end
    end
  endtask

  // Arbiter grants the lowest valid port on the edge after this one
  task automatic expect_grant();
    if (!gnt_expected && req_valid != '0)
    begin
      gnt_expected = 1'b1;
      for (int p = PORTS - 1; p >= 0; p--)
      begin
        if (req_valid[p])
          exp_port = p;
      end
    end
  endtask

  initial
  begin
    int waited;
    void'($urandom(56732));
    rst_n     = 1'b0;
    req_valid = '0;
    sdram_dq  = '0;
    for (int p = 0; p < PORTS; p++)
      req[p] = '0;
    for (int b = 0; b < BANKS; b++)
    begin
      bank_open[b] = 1'b0;
      bank_row[b]  = '0;
      last_act[b]  = -1000;
      last_pre[b]  = -1000;
    end
    for (int i = 0; i <= CAS_LATENCY; i++)
      dq_pipe[i] = '0;
    last_ref     = -T_RC;
    cyc          = 0;
    n_acks       = 0;
    gnt_expected = 1'b0;
    exp_port     = 0;
    waited       = 0;

    repeat (10)
    begin
      @(negedge clk);
      check_idle_outputs();
    end
    rst_n = 1'b1;
    @(negedge clk);
    check_idle_outputs();

    while (n_acks < ACK_TARGET && cyc < RUN_LIMIT)
    begin
      @(negedge clk);
      run_cycle();
      drive_ports();
      expect_grant();
    end

    if (n_acks < ACK_TARGET)
      fail_run("timed out before enough requests were acknowledged");
    else
    begin
      // No new requests, finish the open ones and their read data
      while ((req_valid != '0 || rd_q.size() != 0) && waited < DRAIN_LIMIT)
      begin
        @(negedge clk);
        run_cycle();
        expect_grant();
        waited++;
      end
      if (req_valid != '0 || rd_q.size() != 0)
        fail_run("timed out draining requests and read data");
      else
      begin
        $display("*** TEST PASSED ***");
        $finish;
      end
    end
  end

endmodule

/* logic/sdram_sched_top.sv */
// PORTS from 1 to 4; all timings in clock cycles, each at least 1
`timescale 1ns/1ns

module sdram_sched_top #(
  parameter int PORTS            = 4,
  parameter int T_RCD            = 2,
  parameter int T_RP             = 2,
  parameter int T_RAS            = 5,
  parameter int T_RC             = 7,
  parameter int CAS_LATENCY      = 2,
  parameter int REFRESH_INTERVAL = 780
) (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic [PORTS-1:0]                     req_valid_i,
  input  sdram_sched_pkg::sdram_req_t          req_i [PORTS],
  output logic [PORTS-1:0]                     ack_o,
  output sdram_sched_pkg::sdram_bus_t          sdram_o,
  input  logic [sdram_sched_pkg::DQ_BITS-1:0]  sdram_dq_i,
  output logic [sdram_sched_pkg::DQ_BITS-1:0]  rdq_o,
  output logic [PORTS-1:0]                     rdq_valid_o
);
  import sdram_sched_pkg::*;

  sdram_gnt_t          gnt;
  logic                served;
  bank_state_t         bank_state [BANKS];
  logic [BANKS-1:0]    act;
  logic [BANKS-1:0]    pre;
  logic [ROW_BITS-1:0] row;
  logic                ref_need;
  logic                trc_ok;
  logic                ref_issue;
  rd_launch_t          rd_launch;

  sdram_port_arbiter #(
    .PORTS (PORTS)
  ) u_port_arbiter (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_valid_i (req_valid_i),
    .req_i       (req_i),
    .served_i    (served),
    .gnt_o       (gnt),
    .ack_o       (ack_o)
  );

  for (genvar b = 0; b < BANKS; b++)
  begin : gen_bank
    sdram_bank_timer #(
      .T_RCD (T_RCD),
      .T_RP  (T_RP),
      .T_RAS (T_RAS)
    ) u_bank_timer (
      .clk_i   (clk_i),
      .rst_ni  (rst_ni),
      .act_i   (act[b]),
      .pre_i   (pre[b]),
      .row_i   (row),
      .state_o (bank_state[b])
    );
  end

  sdram_refresh_timer #(
    .REFRESH_INTERVAL (REFRESH_INTERVAL),
    .T_RC             (T_RC)
  ) u_refresh_timer (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .ref_issue_i (ref_issue),
    .ref_need_o  (ref_need),
    .trc_ok_o    (trc_ok)
  );

  sdram_cmd_fsm #(
    .PORTS (PORTS)
  ) u_cmd_fsm (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .gnt_i       (gnt),
    .bank_i      (bank_state),
    .ref_need_i  (ref_need),
    .trc_ok_i    (trc_ok),
    .act_o       (act),
    .pre_o       (pre),
    .row_o       (row),
    .served_o    (served),
    .ref_issue_o (ref_issue),
    .sdram_o     (sdram_o),
    .rd_launch_o (rd_launch)
  );

  sdram_read_return #(
    .PORTS       (PORTS),
    .CAS_LATENCY (CAS_LATENCY)
  ) u_read_return (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .rd_launch_i (rd_launch),
    .sdram_dq_i  (sdram_dq_i),
    .rdq_o       (rdq_o),
    .rdq_valid_o (rdq_valid_o)
  );

endmodule

/* logic/sdram_read_return.sv */
// CAS_LATENCY must be at least 1; read data is shared and only the strobe names the port
`timescale 1ns/1ns

module sdram_read_return #(
  parameter int PORTS       = 4,
  parameter int CAS_LATENCY = 2
) (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  sdram_sched_pkg::rd_launch_t          rd_launch_i,
  input  logic [sdram_sched_pkg::DQ_BITS-1:0]  sdram_dq_i,
  output logic [sdram_sched_pkg::DQ_BITS-1:0]  rdq_o,
  output logic [PORTS-1:0]                     rdq_valid_o
);
  import sdram_sched_pkg::*;

  rd_launch_t queue_q [CAS_LATENCY];
  rd_launch_t head;

  assign head = queue_q[CAS_LATENCY-1];

  // One stage per cycle of CAS latency
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      for (int i = 0; i < CAS_LATENCY; i++)
        queue_q[i] <= '0;
      rdq_valid_o <= '0;
    end
    else
    begin
      queue_q[0] <= rd_launch_i;
      for (int i = 1; i < CAS_LATENCY; i++)
        queue_q[i] <= queue_q[i-1];
      rdq_valid_o <= '0;
      if (head.valid)
        rdq_valid_o[head.port] <= 1'b1;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (head.valid)
      rdq_o <= sdram_dq_i;
  end

  a_one_reader : assert property (
    @(posedge clk_i) disable iff (!rst_ni) head.valid |=> $onehot(rdq_valid_o)
  ) else $error("read data returned without exactly one port strobe");

endmodule

/* logic/sdram_cmd_fsm.sv */
// One command per clock, no auto-precharge; refresh preempts a grant that is not yet served
`timescale 1ns/1ns

module sdram_cmd_fsm #(
  parameter int PORTS = 4
) (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  sdram_sched_pkg::sdram_gnt_t           gnt_i,
  input  sdram_sched_pkg::bank_state_t          bank_i [sdram_sched_pkg::BANKS],
  input  logic                                  ref_need_i,
  input  logic                                  trc_ok_i,
  output logic [sdram_sched_pkg::BANKS-1:0]     act_o,
  output logic [sdram_sched_pkg::BANKS-1:0]     pre_o,
  output logic [sdram_sched_pkg::ROW_BITS-1:0]  row_o,
  output logic                                  served_o,
  output logic                                  ref_issue_o,
  output sdram_sched_pkg::sdram_bus_t           sdram_o,
  output sdram_sched_pkg::rd_launch_t           rd_launch_o
);
  import sdram_sched_pkg::*;

  sdram_cmd_e          nxt_cmd;
  sdram_cmd_e          cmd_q;
  logic [BA_BITS-1:0]  nxt_ba;
  logic [BA_BITS-1:0]  ba_q;
  logic [ROW_BITS-1:0] nxt_addr;
  logic [ROW_BITS-1:0] addr_q;
  logic [DQ_BITS-1:0]  dq_q;
  logic [DM_BITS-1:0]  dm_q;
  rd_launch_t          launch_q;
  bank_state_t         tgt;
  logic                any_active;
  logic                all_rp_ok;
  logic                pre_found;
  logic [BA_BITS-1:0]  pre_ba;

  assign tgt   = bank_i[gnt_i.req.ba];
  assign row_o = gnt_i.req.row;

  //////////////////////////////
  // Bank summary for refresh
  //////////////////////////////
  always_comb
  begin
    any_active = 1'b0;
    all_rp_ok  = 1'b1;
    pre_found  = 1'b0;
    pre_ba     = '0;
    // Descending scan so the lowest bank ready for PRE wins
    for (int b = BANKS - 1; b >= 0; b--)
    begin
      any_active = any_active | bank_i[b].active;
      all_rp_ok  = all_rp_ok & bank_i[b].rp_ok;
      if (bank_i[b].active && bank_i[b].ras_ok)
      begin
        pre_found = 1'b1;
        pre_ba    = BA_BITS'(b);
      end
    end
  end

  //////////////////////////////
  // Command decision
  //////////////////////////////
  always_comb
  begin
    nxt_cmd     = CMD_NOP;
    nxt_ba      = gnt_i.req.ba;
    nxt_addr    = gnt_i.req.row;
    act_o       = '0;
    pre_o       = '0;
    served_o    = 1'b0;
    ref_issue_o = 1'b0;

    if (ref_need_i)
    begin
      // Close every bank, then refresh
      if (any_active)
      begin
        if (pre_found)
        begin
          nxt_cmd        = CMD_PRE;
          nxt_ba         = pre_ba;
          nxt_addr       = '0;
          pre_o[pre_ba]  = 1'b1;
        end
      end
      else if (all_rp_ok && trc_ok_i)
      begin
        nxt_cmd     = CMD_REF;
        ref_issue_o = 1'b1;
      end
    end
    else if (gnt_i.valid)
    begin
      if (tgt.active && tgt.row == gnt_i.req.row)
      begin
        // Row hit
        if (tgt.rcd_ok)
        begin
          nxt_cmd  = gnt_i.req.we ? CMD_WR : CMD_RD;
          nxt_addr = ROW_BITS'(gnt_i.req.col);
          served_o = 1'b1;
        end
      end
      else if (tgt.active)
      begin
        // Row miss, close the wrong row first
        if (tgt.ras_ok)
        begin
          nxt_cmd             = CMD_PRE;
          nxt_addr            = '0;
          pre_o[gnt_i.req.ba] = 1'b1;
        end
      end
      else if (tgt.rp_ok && trc_ok_i)
      begin
        nxt_cmd             = CMD_ACT;
        act_o[gnt_i.req.ba] = 1'b1;
      end
    end
  end

  //////////////////////////////
  // Pin registers
  //////////////////////////////
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      cmd_q    <= CMD_NOP;
      launch_q <= '0;
    end
    else
    begin
      cmd_q          <= nxt_cmd;
      launch_q.valid <= (nxt_cmd == CMD_RD);
      launch_q.port  <= gnt_i.port;
    end
  end

  always_ff @(posedge clk_i)
  begin
    ba_q   <= nxt_ba;
    addr_q <= nxt_addr;
    dq_q   <= gnt_i.req.wdata;
    dm_q   <= ~gnt_i.req.be;
  end

  // Data is driven only in the WR cycle
  assign sdram_o = '{cmd:   cmd_q,
                     ba:    ba_q,
                     addr:  addr_q,
                     dq:    dq_q,
                     dm:    dm_q,
                     dq_oe: cmd_q == CMD_WR};

  assign rd_launch_o = launch_q;

  a_grant_port_in_range : assert property (
    @(posedge clk_i) disable iff (!rst_ni) gnt_i.valid |-> (int'(gnt_i.port) < PORTS)
  ) else $error("grant for a port that does not exist");

endmodule

/* logic/sdram_refresh_timer.sv */
// REFRESH_INTERVAL must be at least 2 and T_RC at least 1; up to 7 refreshes are queued
`timescale 1ns/1ns

module sdram_refresh_timer #(
  parameter int REFRESH_INTERVAL = 780,
  parameter int T_RC             = 7
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic ref_issue_i,
  output logic ref_need_o,
  output logic trc_ok_o
);

  localparam int IW = $clog2(REFRESH_INTERVAL + 1);
  localparam int TW = $clog2(T_RC + 1);

  logic [IW-1:0] interval_q;
  logic [2:0]    pending_q;
  logic [TW-1:0] trc_q;
  logic          wrap;

  assign wrap = (interval_q == '0);

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      interval_q <= IW'(REFRESH_INTERVAL - 1);
    else if (wrap)
      interval_q <= IW'(REFRESH_INTERVAL - 1);
    else
      interval_q <= interval_q - 1'b1;
  end

  // Pending refreshes, saturating at 7
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      pending_q <= '0;
    else if (wrap && !ref_issue_i && pending_q != 3'd7)
      pending_q <= pending_q + 1'b1;
    else if (ref_issue_i && !wrap && pending_q != 3'd0)
      pending_q <= pending_q - 1'b1;
  end

  // REF to next ACT or REF
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      trc_q <= '0;
    else if (ref_issue_i)
      trc_q <= TW'(T_RC - 1);
    else if (trc_q != '0)
      trc_q <= trc_q - 1'b1;
  end

  assign ref_need_o = (pending_q != 3'd0);
  assign trc_ok_o   = (trc_q == '0);

  a_ref_only_when_needed : assert property (
    @(posedge clk_i) disable iff (!rst_ni) ref_issue_i |-> (ref_need_o && trc_ok_o)
  ) else $error("REF issued without a pending refresh");

endmodule

/* logic/sdram_bank_timer.sv */
// All timing parameters are in clock cycles and must be at least 1
`timescale 1ns/1ns

module sdram_bank_timer #(
  parameter int T_RCD = 2,
  parameter int T_RP  = 2,
  parameter int T_RAS = 5
) (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  logic                                  act_i,
  input  logic                                  pre_i,
  input  logic [sdram_sched_pkg::ROW_BITS-1:0]  row_i,
  output sdram_sched_pkg::bank_state_t          state_o
);
  import sdram_sched_pkg::*;

  localparam int T_MAX = (T_RCD > T_RAS) ? ((T_RCD > T_RP) ? T_RCD : T_RP)
                                         : ((T_RAS > T_RP) ? T_RAS : T_RP);
  localparam int CW    = $clog2(T_MAX + 1);

  // Index 0 is tRCD, 1 is tRAS, 2 is tRP
  // A load of T-1 lets the next command appear T cycles after this one
  localparam logic [CW-1:0] LOAD_VAL [3] = '{CW'(T_RCD - 1), CW'(T_RAS - 1), CW'(T_RP - 1)};

  logic [CW-1:0]       cnt_q [3];
  logic [2:0]          load;
  logic                active_q;
  logic [ROW_BITS-1:0] row_q;

  assign load = {pre_i, act_i, act_i};

  //////////////////////////////
  // Down counters
  //////////////////////////////
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      for (int i = 0; i < 3; i++)
        cnt_q[i] <= '0;
    end
    else
    begin
      for (int i = 0; i < 3; i++)
      begin
        if (load[i])
          cnt_q[i] <= LOAD_VAL[i];
        else if (cnt_q[i] != '0)
          cnt_q[i] <= cnt_q[i] - 1'b1;
      end
    end
  end

  // Open row bookkeeping
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      active_q <= 1'b0;
    else if (act_i)
      active_q <= 1'b1;
    else if (pre_i)
      active_q <= 1'b0;
  end

  always_ff @(posedge clk_i)
  begin
    if (act_i)
      row_q <= row_i;
  end

  assign state_o = '{active: active_q,
                     row:    row_q,
                     rcd_ok: cnt_q[0] == '0,
                     ras_ok: cnt_q[1] == '0,
                     rp_ok:  cnt_q[2] == '0};

  a_act_legal : assert property (
    @(posedge clk_i) disable iff (!rst_ni) act_i |-> (!active_q && state_o.rp_ok)
  ) else $error("ACT to an open bank or before tRP");

  a_pre_legal : assert property (
    @(posedge clk_i) disable iff (!rst_ni) pre_i |-> state_o.ras_ok
  ) else $error("PRE before tRAS");

endmodule

/* logic/sdram_port_arbiter.sv */
// Port 0 has the highest priority; a request must stay valid until its ack pulse
`timescale 1ns/1ns

module sdram_port_arbiter #(
  parameter int PORTS = 4
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic [PORTS-1:0]           req_valid_i,
  input  sdram_sched_pkg::sdram_req_t req_i [PORTS],
  input  logic                       served_i,
  output sdram_sched_pkg::sdram_gnt_t gnt_o,
  output logic [PORTS-1:0]           ack_o
);
  import sdram_sched_pkg::*;

  logic                 gnt_valid_q;
  logic [PORT_BITS-1:0] gnt_port_q;
  sdram_req_t           gnt_req_q;
  logic [PORT_BITS-1:0] pick;

  // Lowest numbered valid port wins
  always_comb
  begin
    pick = '0;
    for (int p = PORTS - 1; p >= 0; p--)
    begin
      if (req_valid_i[p])
        pick = PORT_BITS'(p);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      gnt_valid_q <= 1'b0;
      gnt_port_q  <= '0;
      ack_o       <= '0;
    end
    else
    begin
      ack_o <= '0;
      if (served_i)
      begin
        ack_o[gnt_port_q] <= 1'b1;
        gnt_valid_q       <= 1'b0;
      end
      else if (!gnt_valid_q && |req_valid_i)
      begin
        gnt_valid_q <= 1'b1;
        gnt_port_q  <= pick;
      end
    end
  end

  // Request payload captured with the grant
  always_ff @(posedge clk_i)
  begin
    if (!gnt_valid_q)
      gnt_req_q <= req_i[pick];
  end

  assign gnt_o = '{valid: gnt_valid_q, port: gnt_port_q, req: gnt_req_q};

  a_served_needs_grant : assert property (
    @(posedge clk_i) disable iff (!rst_ni) served_i |-> gnt_valid_q
  ) else $error("served without a valid grant");

endmodule

/* logic/sdram_sched_pkg.sv */
// Fixed geometry of 4 banks, 13-bit rows, 9-bit columns and a 16-bit data bus
package sdram_sched_pkg;

  //////////////////////////////
  // Geometry
  //////////////////////////////
  localparam int BANKS     = 4;
  localparam int BA_BITS   = 2;
  localparam int ROW_BITS  = 13;
  localparam int COL_BITS  = 9;
  localparam int DQ_BITS   = 16;
  localparam int DM_BITS   = 2;
  localparam int MAX_PORTS = 4;
  localparam int PORT_BITS = 2;

  // RAS_n, CAS_n, WE_n with chip select held low
  typedef enum logic [2:0] {
    CMD_NOP = 3'b111,
    CMD_ACT = 3'b011,
    CMD_RD  = 3'b101,
    CMD_WR  = 3'b100,
    CMD_PRE = 3'b010,
    CMD_REF = 3'b001
  } sdram_cmd_e;

  //////////////////////////////
  // Shared structs
  //////////////////////////////
  typedef struct packed {
    logic                we;
    logic [BA_BITS-1:0]  ba;
    logic [ROW_BITS-1:0] row;
    logic [COL_BITS-1:0] col;
    logic [DQ_BITS-1:0]  wdata;
    logic [DM_BITS-1:0]  be;
  } sdram_req_t;

  typedef struct packed {
    logic                 valid;
    logic [PORT_BITS-1:0] port;
    sdram_req_t           req;
  } sdram_gnt_t;

  typedef struct packed {
    logic                active;
    logic [ROW_BITS-1:0] row;
    logic                rcd_ok;
    logic                ras_ok;
    logic                rp_ok;
  } bank_state_t;

  typedef struct packed {
    sdram_cmd_e          cmd;
    logic [BA_BITS-1:0]  ba;
    logic [ROW_BITS-1:0] addr;
    logic [DQ_BITS-1:0]  dq;
    logic [DM_BITS-1:0]  dm;
    logic                dq_oe;
  } sdram_bus_t;

  typedef struct packed {
    logic                 valid;
    logic [PORT_BITS-1:0] port;
  } rd_launch_t;

endpackage
